// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_qr_cordic
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/cordic_engine.sv
/* cordic_engine: folded CORDIC, two micro-rotations per cycle over 4 cycles,
   direction memory for vectoring/rotation and a final K scaling cycle */
module cordic_engine (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  qr_pkg::cordic_op_t op,
  output logic               done,
  output qr_pkg::pair_t      result
);
  import qr_pkg::*;

  pair_t               cur_q;
  cordic_mode_t        mode_q;
  logic [iter_w-1:0]   iter_q;
  logic                run_q;
  logic                scale_q;
  logic [num_iter-1:0] dir_q;     // 1 = x and y had equal signs
  logic                busy;
  logic                last_step;
  pair_t               src;
  pair_t               mid;
  pair_t               nxt;
  cordic_mode_t        mode_now;
  logic [iter_w-1:0]   it0;
  logic [iter_w-1:0]   it1;
  logic                d0;
  logic                d1;

  function automatic pair_t micro_rot(pair_t p, logic [iter_w-1:0] sh, logic same);
    elem_t xs;
    elem_t ys;
    pair_t q;
    xs = p.x >>> sh;
    ys = p.y >>> sh;
    if (same) begin
      q.x = p.x + ys;
      q.y = p.y - xs;
    end else begin
      q.x = p.x - ys;
      q.y = p.y + xs;
    end
    return q;
  endfunction

  // 24-bit product, keep sign and bits 21:10
  function automatic elem_t k_scale(elem_t v);
    logic signed [data_w+k_w-1:0] p;
    p = v * k_gain;
    return {p[data_w+k_w-1], p[data_w+k_w-3:k_w-1]};
  endfunction

  always_comb begin
    src      = start ? op.data : cur_q;   // first pair works straight off the op
    mode_now = start ? op.mode : mode_q;
    it0      = start ? '0 : iter_q;
    it1      = it0 + 1'b1;
    d0  = (mode_now == mode_vector) ? (src.x[data_w-1] == src.y[data_w-1]) : dir_q[it0];
    mid = micro_rot(src, it0, d0);
    d1  = (mode_now == mode_vector) ? (mid.x[data_w-1] == mid.y[data_w-1]) : dir_q[it1];
    nxt = micro_rot(mid, it1, d1);
  end

  assign last_step = run_q && (iter_q == iter_w'(num_iter - iter_per_cycle));
  assign busy      = run_q || scale_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_q   <= 1'b0;
      scale_q <= 1'b0;
      done    <= 1'b0;
      iter_q  <= '0;
      mode_q  <= mode_vector;
      dir_q   <= '0;
    end else begin
      scale_q <= last_step;
      done    <= scale_q;
      if (start) begin
        run_q  <= 1'b1;
        iter_q <= iter_w'(iter_per_cycle);
        mode_q <= op.mode;
      end else if (run_q) begin
        iter_q <= iter_q + iter_w'(iter_per_cycle);   // wraps to 0 after step 6
        if (last_step) begin
          run_q <= 1'b0;
        end
      end
      if ((start || run_q) && mode_now == mode_vector) begin
        dir_q[it0] <= d0;
        dir_q[it1] <= d1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start || run_q) begin
      cur_q <= nxt;
    end
    if (scale_q) begin
      result.x <= k_scale(cur_q.x);
      result.y <= k_scale(cur_q.y);
    end
  end

  // sequencer must wait for done before the next op
  a_no_start_busy: assert property (
    @(posedge clk) disable iff (rst) start |-> !busy
  ) else $error("cordic start while an operation is in flight");

endmodule

// File: hdl/givens_sequencer.sv
/* givens_sequencer: load/cal/out phase FSM; walks the Givens schedule
   column by column, bottom row up, one CORDIC operation at a time */
module givens_sequencer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         load_done,
  input  logic                         out_done,
  output qr_pkg::qr_phase_t            phase,
  output logic [qr_pkg::row_idx_w-1:0] pair_row,
  output logic [qr_pkg::col_idx_w-1:0] pair_col,
  input  qr_pkg::pair_t                pair_rdata,
  output qr_pkg::pair_wr_t             pair_wr,
  output logic                         start,
  output qr_pkg::cordic_op_t           op,
  input  logic                         done,
  input  qr_pkg::pair_t                result
);
  import qr_pkg::*;

  logic [col_idx_w-1:0] col_q;    // pivot column
  logic [row_idx_w-1:0] row_q;    // lower row of the pair
  logic [col_idx_w-1:0] jcol_q;   // column under work, == col_q for vectoring
  logic                 busy_q;   // op in flight
  logic [row_idx_w-1:0] first_row;
  logic                 row_end;
  logic                 col_end;
  logic                 last_op;
  logic                 wb;

  assign first_row = row_idx_w'(col_q) + 1'b1;
  assign row_end   = (jcol_q == col_idx_w'(num_cols - 1));
  assign col_end   = row_end && (row_q == first_row);
  assign last_op   = col_end && (col_q == col_idx_w'(num_cols - 1));
  assign wb        = busy_q && done;

  assign pair_row = row_q - 1'b1;
  assign pair_col = jcol_q;

  // issue cycle follows every write back
  assign start = (phase == phase_cal) && !busy_q;

  assign op = '{
    mode: (jcol_q == col_q) ? mode_vector : mode_rotate,
    data: pair_rdata
  };

  // result goes back where it was read from
  assign pair_wr = '{
    we:   wb,
    row:  pair_row,
    col:  jcol_q,
    data: result
  };

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase  <= phase_load;
      busy_q <= 1'b0;
      col_q  <= '0;
      row_q  <= row_idx_w'(num_rows - 1);
      jcol_q <= '0;
    end else begin
      case (phase)
        phase_load: begin
          if (load_done) begin
            phase <= phase_cal;
          end
        end
        phase_cal: begin
          if (start) begin
            busy_q <= 1'b1;
          end else if (wb) begin
            busy_q <= 1'b0;
            if (!row_end) begin
              jcol_q <= jcol_q + 1'b1;          // next rotate column
            end else if (!col_end) begin
              row_q  <= row_q - 1'b1;           // move one row up
              jcol_q <= col_q;
            end else if (!last_op) begin
              col_q  <= col_q + 1'b1;
              row_q  <= row_idx_w'(num_rows - 1);
              jcol_q <= col_q + 1'b1;
            end else begin
              // schedule done, rewind for the next matrix
              col_q  <= '0;
              row_q  <= row_idx_w'(num_rows - 1);
              jcol_q <= '0;
              phase  <= phase_out;
            end
          end
        end
        phase_out: begin
          if (out_done) begin
            phase <= phase_load;
          end
        end
        default: phase <= phase_load;
      endcase
    end
  end

endmodule

// File: hdl/matrix_store.sv
/* matrix_store: 8x4 element register file, whole-row port for load/readout
   and a vertical element-pair port for the Givens operations */
module matrix_store (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         row_we,
  input  logic [qr_pkg::row_idx_w-1:0] row_addr,
  input  qr_pkg::row_t                 row_wdata,
  output qr_pkg::row_t                 row_rdata,
  input  qr_pkg::pair_wr_t             pair_wr,
  input  logic [qr_pkg::row_idx_w-1:0] pair_row,
  input  logic [qr_pkg::col_idx_w-1:0] pair_col,
  output qr_pkg::pair_t                pair_rdata
);
  import qr_pkg::*;

  elem_t                mem [num_rows][num_cols];
  logic [row_idx_w-1:0] wr_lower;
  logic [row_idx_w-1:0] rd_lower;

  assign wr_lower = pair_wr.row + 1'b1;
  assign rd_lower = pair_row + 1'b1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int r = 0; r < num_rows; r++) begin
        for (int c = 0; c < num_cols; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else if (row_we) begin
      mem[row_addr][3] <= row_wdata.c3;
      mem[row_addr][2] <= row_wdata.c2;
      mem[row_addr][1] <= row_wdata.c1;
      mem[row_addr][0] <= row_wdata.c0;
    end else if (pair_wr.we) begin
      mem[pair_wr.row][pair_wr.col] <= pair_wr.data.x;
      mem[wr_lower][pair_wr.col]    <= pair_wr.data.y;
    end
  end

  // combinational reads
  assign row_rdata = '{
    c3: mem[row_addr][3],
    c2: mem[row_addr][2],
    c1: mem[row_addr][1],
    c0: mem[row_addr][0]
  };

  assign pair_rdata = '{
    x: mem[pair_row][pair_col],
    y: mem[rd_lower][pair_col]
  };

  // row_io owns load, the sequencer owns cal, never both at once
  a_one_writer: assert property (
    @(posedge clk) disable iff (rst) !(row_we && pair_wr.we)
  ) else $error("store written by row port and pair port in one cycle");

endmodule

// File: hdl/qr_cordic_top.sv
/* qr_cordic_top: QR triangularization of an 8x4 matrix with one folded
   CORDIC engine, rows in and out over four-phase req/ack */
module qr_cordic_top (
  input  logic         clk,
  input  logic         rst,
  input  logic         in_req,
  output logic         in_ack,
  input  qr_pkg::row_t in_row,
  output logic         out_req,
  input  logic         out_ack,
  output qr_pkg::row_t out_row
);
  import qr_pkg::*;

  logic                 row_we;
  logic [row_idx_w-1:0] row_addr;
  row_t                 row_wdata;
  row_t                 row_rdata;
  pair_wr_t             pair_wr;
  logic [row_idx_w-1:0] pair_row;
  logic [col_idx_w-1:0] pair_col;
  pair_t                pair_rdata;
  qr_phase_t            phase;
  logic                 load_done;
  logic                 out_done;
  logic                 start;
  cordic_op_t           op;
  logic                 done;
  pair_t                result;

  matrix_store u_store (
    .clk        (clk),
    .rst        (rst),
    .row_we     (row_we),
    .row_addr   (row_addr),
    .row_wdata  (row_wdata),
    .row_rdata  (row_rdata),
    .pair_wr    (pair_wr),
    .pair_row   (pair_row),
    .pair_col   (pair_col),
    .pair_rdata (pair_rdata)
  );

  row_io u_io (
    .clk       (clk),
    .rst       (rst),
    .phase     (phase),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .in_row    (in_row),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_row   (out_row),
    .row_we    (row_we),
    .row_addr  (row_addr),
    .row_wdata (row_wdata),
    .row_rdata (row_rdata),
    .load_done (load_done),
    .out_done  (out_done)
  );

  givens_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .load_done  (load_done),
    .out_done   (out_done),
    .phase      (phase),
    .pair_row   (pair_row),
    .pair_col   (pair_col),
    .pair_rdata (pair_rdata),
    .pair_wr    (pair_wr),
    .start      (start),
    .op         (op),
    .done       (done),
    .result     (result)
  );

  cordic_engine u_cordic (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op     (op),
    .done   (done),
    .result (result)
  );

endmodule

// File: hdl/qr_pkg.sv
/* qr_pkg: widths, constants, enums and packed structs shared by the
   folded CORDIC QR triangularization core */
package qr_pkg;

  localparam int data_w         = 13;
  localparam int num_rows       = 8;
  localparam int num_cols       = 4;
  localparam int row_idx_w      = 3;
  localparam int col_idx_w      = 2;
  localparam int num_iter       = 8;
  localparam int iter_per_cycle = 2;
  localparam int iter_w         = 3;   // indexes the 8 micro-rotations
  localparam int k_w            = 11;

  // 1/K of the 8-step CORDIC, Q1.10
  localparam logic signed [k_w-1:0] k_gain = 11'sd622;

  typedef logic signed [data_w-1:0] elem_t;

  typedef struct packed {
    elem_t c3;
    elem_t c2;
    elem_t c1;
    elem_t c0;
  } row_t;

  // x is the upper row, y the one below it
  typedef struct packed {
    elem_t x;
    elem_t y;
  } pair_t;

  typedef enum logic {
    mode_vector,
    mode_rotate
  } cordic_mode_t;

  typedef struct packed {
    cordic_mode_t mode;
    pair_t        data;
  } cordic_op_t;

  typedef struct packed {
    logic                 we;
    logic [row_idx_w-1:0] row;   // upper row, y lands on row+1
    logic [col_idx_w-1:0] col;
    pair_t                data;
  } pair_wr_t;

  typedef enum logic [1:0] {
    phase_load,
    phase_cal,
    phase_out
  } qr_phase_t;

endpackage

// File: hdl/row_io.sv
/* row_io: four-phase req/ack for loading rows into the store and
   reading the triangularized rows back out, one row counter for both */
module row_io (
  input  logic                         clk,
  input  logic                         rst,
  input  qr_pkg::qr_phase_t            phase,
  input  logic                         in_req,
  output logic                         in_ack,
  input  qr_pkg::row_t                 in_row,
  output logic                         out_req,
  input  logic                         out_ack,
  output qr_pkg::row_t                 out_row,
  output logic                         row_we,
  output logic [qr_pkg::row_idx_w-1:0] row_addr,
  output qr_pkg::row_t                 row_wdata,
  input  qr_pkg::row_t                 row_rdata,
  output logic                         load_done,
  output logic                         out_done
);
  import qr_pkg::*;

  logic [row_idx_w-1:0] cnt_q;
  logic                 out_fin_q;   // last row sent, waiting for ack release
  logic                 out_hs;
  logic                 out_last;

  assign out_hs   = out_req && out_ack;
  assign out_last = (cnt_q == row_idx_w'(num_rows - 1));

  assign row_addr  = cnt_q;
  assign row_wdata = in_row;
  assign row_we    = (phase == phase_load) && in_req && !in_ack;
  assign out_row   = row_rdata;

  // counter has wrapped to 0 after row 7
  assign load_done = in_ack && !in_req && (cnt_q == '0);
  assign out_done  = out_fin_q && !out_ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      in_ack    <= 1'b0;
      out_req   <= 1'b0;
      cnt_q     <= '0;
      out_fin_q <= 1'b0;
    end else begin
      if (row_we) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end

      if (phase == phase_out && !out_req && !out_ack && !out_fin_q) begin
        out_req <= 1'b1;
      end else if (out_hs) begin
        out_req <= 1'b0;
      end

      if (row_we || out_hs) begin
        cnt_q <= cnt_q + 1'b1;
      end

      if (out_hs && out_last) begin
        out_fin_q <= 1'b1;
      end else if (out_done) begin
        out_fin_q <= 1'b0;
      end
    end
  end

  // row must hold until the consumer takes it
  a_out_hold: assert property (
    @(posedge clk) disable iff (rst) (out_req && !out_ack) |=> $stable(out_row)
  ) else $error("out_row changed while out_req waits for out_ack");

endmodule

// File: sim/qr_model.svh
/* qr_model: bit-exact reference for the folded CORDIC QR core,
   micro-rotation, K scaling and the full Givens schedule */
`ifndef qr_model_svh
`define qr_model_svh

// row r, column c; column 3 is the top field like row_t
typedef elem_t [num_rows-1:0][num_cols-1:0] matrix_t;

function automatic pair_t rotate_step(pair_t p, int i, logic same);
  elem_t x;
  elem_t y;
  pair_t q;
  x = p.x;
  y = p.y;
  if (same) begin
    q.x = x + (y >>> i);
    q.y = y - (x >>> i);
  end else begin
    q.x = x - (y >>> i);
    q.y = y + (x >>> i);
  end
  return q;
endfunction

function automatic elem_t scale_elem(elem_t v);
  logic signed [23:0] a;
  logic signed [23:0] b;
  logic signed [23:0] p;
  a = 24'(v);
  b = 24'(k_gain);
  p = a * b;
  return {p[23], p[21:10]};   // drops bit 22
endfunction

function automatic pair_t givens_op(pair_t p, logic vec, inout logic [num_iter-1:0] dirs);
  pair_t q;
  elem_t x;
  elem_t y;
  logic  same;
  q = p;
  for (int i = 0; i < num_iter; i++) begin
    x = q.x;
    y = q.y;
    same = vec ? (x[data_w-1] == y[data_w-1]) : dirs[i];
    if (vec) begin
      dirs[i] = same;   // rotate ops replay these
    end
    q = rotate_step(q, i, same);
  end
  q.x = scale_elem(q.x);
  q.y = scale_elem(q.y);
  return q;
endfunction

function automatic matrix_t triangularize(matrix_t m);
  logic [num_iter-1:0] dirs;
  pair_t               p;
  dirs = '0;
  for (int c = 0; c < num_cols; c++) begin
    for (int r = num_rows - 1; r > c; r--) begin
      for (int j = c; j < num_cols; j++) begin
        p.x = m[r-1][j];
        p.y = m[r][j];
        p = givens_op(p, j == c, dirs);
        m[r-1][j] = p.x;
        m[r][j] = p.y;
      end
    end
  end
  return m;
endfunction

`endif

// File: sim/tb_qr_cordic.sv
/* tb_qr_cordic: testbench for the CORDIC QR core, loads a table of
   matrices over req/ack and checks the rows read back against the model */
module tb_qr_cordic;
  import qr_pkg::*;

  `include "qr_model.svh"

  localparam int num_cases = 4;

  typedef struct {
    matrix_t a;
    matrix_t expected;
    int      ack_delay;   // cycles before out_ack
  } case_t;

  logic  clk;
  logic  rst;
  logic  in_req;
  logic  in_ack;
  row_t  in_row;
  logic  out_req;
  logic  out_ack;
  row_t  out_row;
  int    errors;
  int    timeouts;
  case_t cases [num_cases];

  qr_cordic_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_row  (in_row),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_row (out_row)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic row_t make_row(int c0, int c1, int c2, int c3);
    return {elem_t'(c3), elem_t'(c2), elem_t'(c1), elem_t'(c0)};
  endfunction

  task automatic build_cases();
    matrix_t     m;
    logic [31:0] seed;
    seed = 32'ha363_40d0;
    m = '0;
    cases[0].a = m;
    cases[0].ack_delay = 0;
    for (int i = 0; i < num_cols; i++) begin
      m[i][i] = elem_t'(256);   // 0.25 in Q1.10
    end
    cases[1].a = m;
    cases[1].ack_delay = 1;
    m[0] = make_row(100, -37, 250, 12);
    m[1] = make_row(-600, 45, 0, 300);
    m[2] = make_row(7, 600, -128, -5);
    m[3] = make_row(311, -299, 64, 480);
    m[4] = make_row(-1, 2, -3, 4);
    m[5] = make_row(555, 0, -555, 123);
    m[6] = make_row(0, -421, 88, -600);
    m[7] = make_row(200, 199, -198, 197);
    cases[2].a = m;
    cases[2].ack_delay = 3;
    for (int r = 0; r < num_rows; r++) begin
      for (int c = 0; c < num_cols; c++) begin
        seed = xorshift32(seed);
        m[r][c] = elem_t'(int'(seed % 32'd1201) - 600);
      end
    end
    cases[3].a = m;
    cases[3].ack_delay = 6;
    for (int t = 0; t < num_cases; t++) begin
      cases[t].expected = triangularize(cases[t].a);
    end
  endtask

  task automatic check_row(string name, row_t got, row_t exp);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_in_ack(logic level, int limit);
    int n;
    n = 0;
    while (in_ack !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (in_ack !== level) begin
      $display("ERROR: in_ack did not go to %0d within %0d cycles", level, limit);
      timeouts++;
    end
  endtask

  task automatic wait_out_req(logic level, int limit);
    int n;
    n = 0;
    while (out_req !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (out_req !== level) begin
      $display("ERROR: out_req did not go to %0d within %0d cycles", level, limit);
      timeouts++;
    end
  endtask

  task automatic load_matrix(int t);
    for (int r = 0; r < num_rows; r++) begin
      @(negedge clk);
      in_row = row_t'(cases[t].a[r]);
      in_req = 1'b1;
      wait_in_ack(1'b1, 20);
      if (timeouts != 0) return;
      check_bit("out_req", out_req, 1'b0);   // nothing out before the last row
      @(negedge clk);
      check_bit("in_ack", in_ack, 1'b1);     // held while in_req is high
      in_req = 1'b0;
      wait_in_ack(1'b0, 20);
      if (timeouts != 0) return;
    end
  endtask

  task automatic read_matrix(int t);
    row_t exp;
    for (int r = 0; r < num_rows; r++) begin
      exp = row_t'(cases[t].expected[r]);
      wait_out_req(1'b1, 1000);   // first row waits out the cal phase
      if (timeouts != 0) return;
      check_row($sformatf("out_row[%0d]", r), out_row, exp);
      for (int d = 0; d < cases[t].ack_delay; d++) begin
        @(negedge clk);
        check_bit("out_req", out_req, 1'b1);
        check_row($sformatf("out_row[%0d]", r), out_row, exp);
      end
      out_ack = 1'b1;
      wait_out_req(1'b0, 20);
      if (timeouts != 0) return;
      out_ack = 1'b0;
    end
  endtask

  initial begin
    rst = 1'b1;
    in_req = 1'b0;
    in_row = '0;
    out_ack = 1'b0;
    errors = 0;
    timeouts = 0;
    build_cases();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("in_ack", in_ack, 1'b0);
    check_bit("out_req", out_req, 1'b0);
    // no reset between matrices
    for (int t = 0; t < num_cases; t++) begin
      if (timeouts != 0) break;
      load_matrix(t);
      if (timeouts == 0) begin
        read_matrix(t);
      end
    end
    $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+sim
hdl/qr_pkg.sv
hdl/matrix_store.sv
hdl/row_io.sv
hdl/givens_sequencer.sv
hdl/cordic_engine.sv
hdl/qr_cordic_top.sv
sim/tb_qr_cordic.sv
